//--- Makefile
# Verilator build and run for the burst mapper testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := burst_map_tb
FILELIST := tb.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# The binary is rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status is that of the search for the pass line
run: $(BIN)
	@./$(BIN) | tee /dev/stderr | grep -q '^TB PASSED$$'

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/burst_gearbox.sv
// Splits one master burst into power-of-two memory bursts; a new master burst overrides any leftover
`timescale 1ns/1ns

module burst_gearbox
    import burst_map_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     m_new_req,
    input  addr_t    m_addr,
    input  m_burst_t m_burstcount,
    input  logic     s_accept_req,
    output logic     s_req_complete,
    output addr_t    s_addr,
    output s_burst_t s_burstcount
);

    // Address of the next memory burst to offer
    addr_t cur_addr;

    // Beats of the master burst that have not been offered yet
    m_burst_t cur_cnt;

    // Size of the memory burst currently on offer
    s_burst_t offer;

    // Pick the largest power of two that fits the remaining count
    // and, when alignment is required, divides the current address
    always_comb
    begin
        logic aligned;

        offer = s_burst_t'(1);
        for (int i = 1; i < S_BURST_WIDTH; i++)
        begin
            if (NATURAL_ALIGNMENT)
            begin
                aligned = ((cur_addr & addr_t'((1 << i) - 1)) == '0);
            end
            else
            begin
                aligned = 1'b1;
            end

            // Sizes are tried in rising order, so the last hit is the largest
            if (aligned && (cur_cnt >= m_burst_t'(1 << i)))
            begin
                offer = s_burst_t'(1 << i);
            end
        end
    end

    assign s_addr = cur_addr;
    assign s_burstcount = offer;

    // The offered burst is the last piece when it drains the remaining count
    // Zero remaining means idle, which never matches a nonzero offer
    assign s_req_complete = (m_burst_t'(offer) == cur_cnt);

    always_ff @(posedge clk)
    begin
        if (m_new_req)
        begin
            // A new master burst only arrives after the previous one is fully offered
            cur_addr <= m_addr;
            cur_cnt <= m_burstcount;
        end
        else if (s_accept_req)
        begin
            cur_addr <= cur_addr + addr_t'(offer);
            cur_cnt <= cur_cnt - m_burst_t'(offer);
        end

        if (!reset_n)
        begin
            cur_cnt <= '0;
        end
    end

endmodule

//--- rtl/burst_map_pkg.sv
// Shared widths and request/response structs; memory bursts are powers of two up to S_MAX_BURST beats
package burst_map_pkg;

    // Word address, data and user flag widths shared by both sides
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int USER_WIDTH = 4;
    localparam int BYTEEN_WIDTH = DATA_WIDTH / 8;

    // Master bursts carry 1 to 16 beats and memory bursts carry 1 to 4 beats
    localparam int M_BURST_WIDTH = 5;
    localparam int S_BURST_WIDTH = 3;
    localparam int S_MAX_BURST = 1 << (S_BURST_WIDTH - 1);

    // User bit that marks a memory burst whose write response must be swallowed
    localparam int UFLAG_NO_REPLY = 0;

    // Memory bursts must start on a multiple of their own length
    localparam bit NATURAL_ALIGNMENT = 1'b1;

    // The memory model decodes only the low address bits
    localparam int MEM_ADDR_WIDTH = 8;
    localparam int MEM_DEPTH = 1 << MEM_ADDR_WIDTH;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [USER_WIDTH-1:0] user_t;
    typedef logic [BYTEEN_WIDTH-1:0] byteen_t;
    typedef logic [M_BURST_WIDTH-1:0] m_burst_t;
    typedef logic [S_BURST_WIDTH-1:0] s_burst_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_idx_t;

    typedef struct packed {
        logic read;
        addr_t address;
        m_burst_t burstcount;
        user_t user;
    } m_rd_req_t;

    typedef struct packed {
        logic read;
        addr_t address;
        s_burst_t burstcount;
        user_t user;
    } s_rd_req_t;

    typedef struct packed {
        logic write;
        addr_t address;
        m_burst_t burstcount;
        data_t writedata;
        byteen_t byteenable;
        user_t user;
    } m_wr_req_t;

    typedef struct packed {
        logic write;
        addr_t address;
        s_burst_t burstcount;
        data_t writedata;
        byteen_t byteenable;
        user_t user;
    } s_wr_req_t;

    typedef struct packed {
        logic readdatavalid;
        data_t readdata;
        user_t readresponseuser;
    } rd_rsp_t;

    typedef struct packed {
        logic writeresponsevalid;
        user_t writeresponseuser;
    } wr_rsp_t;

endpackage

//--- rtl/burst_map_rdwr.sv
// Maps 16-beat master bursts onto 4-beat memory bursts; the memory must echo user bits on responses
`timescale 1ns/1ns

module burst_map_rdwr
    import burst_map_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    input  m_rd_req_t m_rd_req,
    output logic      m_rd_waitrequest,
    output rd_rsp_t   m_rd_rsp,
    input  m_wr_req_t m_wr_req,
    output logic      m_wr_waitrequest,
    output wr_rsp_t   m_wr_rsp,

    output s_rd_req_t s_rd_req,
    input  logic      s_rd_waitrequest,
    input  rd_rsp_t   s_rd_rsp,
    output s_wr_req_t s_wr_req,
    input  logic      s_wr_waitrequest,
    input  wr_rsp_t   s_wr_rsp
);

    // Read side state
    logic rd_next;
    logic rd_complete;
    logic s_rd_read;
    user_t s_rd_user;
    addr_t s_rd_addr;
    s_burst_t s_rd_burstcount;

    // Write side state
    logic wr_complete;
    logic m_wr_sop;
    logic s_wr_sop;
    logic s_wr_write;
    data_t s_wr_data;
    byteen_t s_wr_be;
    user_t s_wr_user;
    addr_t s_wr_addr;
    s_burst_t s_wr_burstcount;

    // A new master read is taken when the memory is free and nothing of the
    // previous master burst is left to issue
    assign rd_next = !s_rd_waitrequest && (!s_rd_read || rd_complete);
    assign m_rd_waitrequest = !rd_next;

    burst_gearbox rd_gearbox (
        .clk            (clk),
        .reset_n        (reset_n),
        .m_new_req      (rd_next && m_rd_req.read),
        .m_addr         (m_rd_req.address),
        .m_burstcount   (m_rd_req.burstcount),
        .s_accept_req   (s_rd_read && !s_rd_waitrequest),
        .s_req_complete (rd_complete),
        .s_addr         (s_rd_addr),
        .s_burstcount   (s_rd_burstcount)
    );

    always_ff @(posedge clk)
    begin
        if (rd_next)
        begin
            s_rd_read <= m_rd_req.read;
            s_rd_user <= m_rd_req.user;
            // Every read piece must return data, so none is marked for dropping
            s_rd_user[UFLAG_NO_REPLY] <= 1'b0;
        end

        if (!reset_n)
        begin
            s_rd_read <= 1'b0;
        end
    end

    always_comb
    begin
        s_rd_req.read = s_rd_read;
        s_rd_req.address = s_rd_addr;
        s_rd_req.burstcount = s_rd_burstcount;
        s_rd_req.user = s_rd_user;
    end

    // Read data carries no burst framing and goes straight back
    assign m_rd_rsp = s_rd_rsp;

    // Writes are stalled only by the memory itself
    assign m_wr_waitrequest = s_wr_waitrequest;

    burst_gearbox wr_gearbox (
        .clk            (clk),
        .reset_n        (reset_n),
        .m_new_req      (m_wr_req.write && !s_wr_waitrequest && m_wr_sop),
        .m_addr         (m_wr_req.address),
        .m_burstcount   (m_wr_req.burstcount),
        .s_accept_req   (s_wr_write && !s_wr_waitrequest && s_wr_sop),
        .s_req_complete (wr_complete),
        .s_addr         (s_wr_addr),
        .s_burstcount   (s_wr_burstcount)
    );

    burst_sop_tracker #(
        .BURST_CNT_WIDTH (M_BURST_WIDTH)
    ) m_sop_tracker (
        .clk        (clk),
        .reset_n    (reset_n),
        .flit_valid (m_wr_req.write && !m_wr_waitrequest),
        .burstcount (m_wr_req.burstcount),
        .sop        (m_wr_sop)
    );

    burst_sop_tracker #(
        .BURST_CNT_WIDTH (S_BURST_WIDTH)
    ) s_sop_tracker (
        .clk        (clk),
        .reset_n    (reset_n),
        .flit_valid (s_wr_write && !s_wr_waitrequest),
        .burstcount (s_wr_burstcount),
        .sop        (s_wr_sop)
    );

    // Each accepted beat is held for exactly one cycle unless the memory stalls
    always_ff @(posedge clk)
    begin
        if (!s_wr_waitrequest)
        begin
            s_wr_write <= m_wr_req.write;
            s_wr_data <= m_wr_req.writedata;
            s_wr_be <= m_wr_req.byteenable;
            // User bits are only valid on the master's first beat
            if (m_wr_req.write && m_wr_sop)
            begin
                s_wr_user <= m_wr_req.user;
            end
        end

        if (!reset_n)
        begin
            s_wr_write <= 1'b0;
        end
    end

    always_comb
    begin
        s_wr_req.write = s_wr_write;
        s_wr_req.address = s_wr_addr;
        s_wr_req.burstcount = s_wr_burstcount;
        s_wr_req.writedata = s_wr_data;
        s_wr_req.byteenable = s_wr_be;
        s_wr_req.user = s_wr_user;
        // Only the last piece of a master burst may produce a visible response
        s_wr_req.user[UFLAG_NO_REPLY] = !(wr_complete && s_wr_sop);
    end

    // Responses to injected pieces are swallowed here
    assign m_wr_rsp.writeresponsevalid = s_wr_rsp.writeresponsevalid
                                         && !s_wr_rsp.writeresponseuser[UFLAG_NO_REPLY];
    assign m_wr_rsp.writeresponseuser = s_wr_rsp.writeresponseuser;

endmodule

//--- rtl/burst_map_top.sv
// Top level with the burst mapper in front of the memory model; master user bit 0 must be driven low
`timescale 1ns/1ns

module burst_map_top
    import burst_map_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  m_rd_req_t rd_req,
    output logic      rd_waitrequest,
    output rd_rsp_t   rd_rsp,
    input  m_wr_req_t wr_req,
    output logic      wr_waitrequest,
    output wr_rsp_t   wr_rsp
);

    // Memory side of the mapper
    s_rd_req_t s_rd_req;
    logic s_rd_waitrequest;
    rd_rsp_t s_rd_rsp;
    s_wr_req_t s_wr_req;
    logic s_wr_waitrequest;
    wr_rsp_t s_wr_rsp;

    burst_map_rdwr mapper (
        .clk              (clk),
        .reset_n          (reset_n),
        .m_rd_req         (rd_req),
        .m_rd_waitrequest (rd_waitrequest),
        .m_rd_rsp         (rd_rsp),
        .m_wr_req         (wr_req),
        .m_wr_waitrequest (wr_waitrequest),
        .m_wr_rsp         (wr_rsp),
        .s_rd_req         (s_rd_req),
        .s_rd_waitrequest (s_rd_waitrequest),
        .s_rd_rsp         (s_rd_rsp),
        .s_wr_req         (s_wr_req),
        .s_wr_waitrequest (s_wr_waitrequest),
        .s_wr_rsp         (s_wr_rsp)
    );

    burst_mem_model mem (
        .clk            (clk),
        .reset_n        (reset_n),
        .rd_req         (s_rd_req),
        .rd_waitrequest (s_rd_waitrequest),
        .rd_rsp         (s_rd_rsp),
        .wr_req         (s_wr_req),
        .wr_waitrequest (s_wr_waitrequest),
        .wr_rsp         (s_wr_rsp)
    );

endmodule

//--- rtl/burst_mem_model.sv
// Memory model of 256 words that wraps on the low address bits and has no read-after-write ordering
`timescale 1ns/1ns

module burst_mem_model
    import burst_map_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  s_rd_req_t rd_req,
    output logic      rd_waitrequest,
    output rd_rsp_t   rd_rsp,
    input  s_wr_req_t wr_req,
    output logic      wr_waitrequest,
    output wr_rsp_t   wr_rsp
);

    data_t mem [MEM_DEPTH];

    // Read sequencer state
    logic rd_active;
    mem_idx_t rd_ptr;
    s_burst_t rd_left;
    user_t rd_user;
    logic rd_valid_q;
    data_t rd_data_q;
    user_t rd_user_q;

    // Write port state
    logic [2:0] refresh_cnt;
    s_burst_t wr_left;
    mem_idx_t wr_ptr;
    user_t wr_user;
    logic wr_accept;
    logic wr_sop;
    logic wr_last;
    mem_idx_t wr_idx;
    user_t beat_user;

    // Response pipeline toward the write response port
    logic wr_p1_valid;
    user_t wr_p1_user;
    logic wr_rsp_valid_q;
    user_t wr_rsp_user_q;

    // A read burst is taken only while no other burst is streaming
    assign rd_waitrequest = rd_active;

    always_ff @(posedge clk)
    begin
        if (rd_req.read && !rd_waitrequest)
        begin
            rd_active <= 1'b1;
            rd_ptr <= rd_req.address[MEM_ADDR_WIDTH-1:0];
            rd_left <= rd_req.burstcount;
            rd_user <= rd_req.user;
        end
        else if (rd_active)
        begin
            rd_ptr <= rd_ptr + mem_idx_t'(1);
            rd_left <= rd_left - s_burst_t'(1);
            if (rd_left == s_burst_t'(1))
            begin
                rd_active <= 1'b0;
            end
        end

        // One word per cycle lands on the response port a cycle later
        rd_valid_q <= rd_active;
        rd_data_q <= mem[rd_ptr];
        rd_user_q <= rd_user;

        if (!reset_n)
        begin
            rd_active <= 1'b0;
            rd_valid_q <= 1'b0;
        end
    end

    assign rd_rsp.readdatavalid = rd_valid_q;
    assign rd_rsp.readdata = rd_data_q;
    assign rd_rsp.readresponseuser = rd_user_q;

    // Refresh steals one write slot out of every eight cycles
    assign wr_waitrequest = (refresh_cnt == 3'd7);

    assign wr_accept = wr_req.write && !wr_waitrequest;
    assign wr_sop = (wr_left == '0);
    assign wr_last = wr_sop ? (wr_req.burstcount == s_burst_t'(1)) : (wr_left == s_burst_t'(1));
    assign wr_idx = wr_sop ? wr_req.address[MEM_ADDR_WIDTH-1:0] : wr_ptr;
    // Single-beat bursts finish before their user bits could be stored
    assign beat_user = wr_sop ? wr_req.user : wr_user;

    always_ff @(posedge clk)
    begin
        refresh_cnt <= refresh_cnt + 3'd1;

        if (wr_accept)
        begin
            for (int i = 0; i < BYTEEN_WIDTH; i++)
            begin
                if (wr_req.byteenable[i])
                begin
                    mem[wr_idx][8*i +: 8] <= wr_req.writedata[8*i +: 8];
                end
            end

            wr_ptr <= wr_idx + mem_idx_t'(1);
            if (wr_sop)
            begin
                wr_left <= wr_req.burstcount - s_burst_t'(1);
                wr_user <= wr_req.user;
            end
            else
            begin
                wr_left <= wr_left - s_burst_t'(1);
            end
        end

        // Two stages from the last beat to the response
        wr_p1_valid <= wr_accept && wr_last;
        wr_p1_user <= beat_user;
        wr_rsp_valid_q <= wr_p1_valid;
        wr_rsp_user_q <= wr_p1_user;

        if (!reset_n)
        begin
            refresh_cnt <= '0;
            wr_left <= '0;
            wr_p1_valid <= 1'b0;
            wr_rsp_valid_q <= 1'b0;
        end
    end

    assign wr_rsp.writeresponsevalid = wr_rsp_valid_q;
    assign wr_rsp.writeresponseuser = wr_rsp_user_q;

endmodule

//--- rtl/burst_sop_tracker.sv
// Tracks write burst framing from accepted beats only; burstcount is sampled on the first beat
`timescale 1ns/1ns

module burst_sop_tracker #(
    parameter int BURST_CNT_WIDTH = 3
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       flit_valid,
    input  logic [BURST_CNT_WIDTH-1:0] burstcount,
    output logic                       sop
);

    // Beats still owed by the burst in flight, zero between bursts
    logic [BURST_CNT_WIDTH-1:0] beats_left;

    // The next accepted beat opens a new burst when nothing is owed
    assign sop = (beats_left == '0);

    always_ff @(posedge clk)
    begin
        if (flit_valid)
        begin
            if (sop)
            begin
                // The first beat itself is consumed here
                beats_left <= burstcount - BURST_CNT_WIDTH'(1);
            end
            else
            begin
                beats_left <= beats_left - BURST_CNT_WIDTH'(1);
            end
        end

        if (!reset_n)
        begin
            beats_left <= '0;
        end
    end

endmodule

//--- tb.f
rtl/burst_map_pkg.sv
rtl/burst_sop_tracker.sv
rtl/burst_gearbox.sv
rtl/burst_map_rdwr.sv
rtl/burst_mem_model.sv
rtl/burst_map_top.sv
verification/burst_map_props.sv
verification/burst_map_tb.sv

//--- verification/burst_map_props.sv
// Mapper burst checks; counters assume no write burst is in flight when reset is released
`timescale 1ns/1ns

module burst_map_props
    import burst_map_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input m_wr_req_t m_wr_req,
    input logic      m_wr_waitrequest,
    input logic      m_wr_sop,
    input wr_rsp_t   m_wr_rsp,
    input s_rd_req_t s_rd_req,
    input s_wr_req_t s_wr_req,
    input logic      s_wr_sop
);

    // Master write bursts whose first beat went in
    int m_bursts;
    // Write responses handed back to the master
    int fwd_rsps;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            m_bursts <= 0;
            fwd_rsps <= 0;
        end
        else
        begin
            if (m_wr_req.write && !m_wr_waitrequest && m_wr_sop)
            begin
                m_bursts <= m_bursts + 1;
            end
            if (m_wr_rsp.writeresponsevalid)
            begin
                fwd_rsps <= fwd_rsps + 1;
            end
        end
    end

    // Memory reads stay within 1 to 4 beats
    rd_len_legal: assert property (@(posedge clk) disable iff (!reset_n)
        s_rd_req.read |-> (s_rd_req.burstcount != '0)
                          && (s_rd_req.burstcount <= s_burst_t'(S_MAX_BURST)))
    else $error("memory read burst count out of range");

    // Write framing fields only matter on the first beat of a piece
    wr_len_legal: assert property (@(posedge clk) disable iff (!reset_n)
        (s_wr_req.write && s_wr_sop) |-> (s_wr_req.burstcount != '0)
                                         && (s_wr_req.burstcount <= s_burst_t'(S_MAX_BURST)))
    else $error("memory write burst count out of range");

    rd_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        s_rd_req.read |->
            ((s_rd_req.address & (addr_t'(s_rd_req.burstcount) - addr_t'(1))) == '0))
    else $error("memory read burst not aligned to its length");

    wr_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        (s_wr_req.write && s_wr_sop) |->
            ((s_wr_req.address & (addr_t'(s_wr_req.burstcount) - addr_t'(1))) == '0))
    else $error("memory write burst not aligned to its length");

    // A response cannot show up before the burst it answers has started
    rsp_bounded: assert property (@(posedge clk) disable iff (!reset_n)
        (fwd_rsps + int'(m_wr_rsp.writeresponsevalid)) <= m_bursts)
    else $error("more write responses forwarded than master write bursts");

endmodule

bind burst_map_rdwr burst_map_props props (
    .clk              (clk),
    .reset_n          (reset_n),
    .m_wr_req         (m_wr_req),
    .m_wr_waitrequest (m_wr_waitrequest),
    .m_wr_sop         (m_wr_sop),
    .m_wr_rsp         (m_wr_rsp),
    .s_rd_req         (s_rd_req),
    .s_wr_req         (s_wr_req),
    .s_wr_sop         (s_wr_sop)
);

//--- verification/burst_map_tb.sv
// Bursts run one at a time, so the memory never sees a read racing a write to the same word
`timescale 1ns/1ns

module burst_map_tb
    import burst_map_pkg::*;
;

    localparam int unsigned SEED = 32'h983d6185;
    localparam int N_FILL = MEM_DEPTH / 16;
    localparam int N_DIRECTED = 8;
    localparam int N_RANDOM = 200;
    localparam int N_BURSTS = N_FILL + N_DIRECTED + N_RANDOM;
    // Each burst gets 16 beats of 8 cycles of 4 ns, plus slack for reset and drain
    localparam int TIMEOUT_NS = N_BURSTS * 16 * 8 * 4 + 2000;

    logic clk;
    logic reset_n;
    m_rd_req_t rd_req;
    logic rd_waitrequest;
    rd_rsp_t rd_rsp;
    m_wr_req_t wr_req;
    logic wr_waitrequest;
    wr_rsp_t wr_rsp;

    // Shadow of the memory contents as the master has written them
    data_t shadow [MEM_DEPTH];
    data_t rd_exp_q [$];
    addr_t rd_addr_q [$];
    user_t rd_user_q [$];
    user_t wr_user_q [$];
    int rd_len_total;
    int wr_bursts;
    int rd_words;
    int wr_rsps;

    burst_map_top dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .rd_req         (rd_req),
        .rd_waitrequest (rd_waitrequest),
        .rd_rsp         (rd_rsp),
        .wr_req         (wr_req),
        .wr_waitrequest (wr_waitrequest),
        .wr_rsp         (wr_rsp)
    );

    always #2 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // Initial contents mix both halves of the full address
    function automatic data_t fill_word(input addr_t a);
        return {a ^ 16'h3c5a, ~a};
    endfunction

    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                          input byteen_t be);
        data_t w;
        w = old_w;
        for (int i = 0; i < BYTEEN_WIDTH; i++)
        begin
            if (be[i])
            begin
                w[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return w;
    endfunction

    // The memory decodes only the low address bits, so the shadow wraps the same way
    function automatic data_t ref_word(input addr_t a);
        return shadow[a[MEM_ADDR_WIDTH-1:0]];
    endfunction

    // A zero be_force picks random byte enables per beat
    task automatic write_burst(input addr_t addr, input int len, input user_t user,
                               input bit fill, input byteen_t be_force);
        data_t d;
        byteen_t be;
        addr_t a;
        wr_user_q.push_back(user);
        wr_bursts += 1;
        for (int i = 0; i < len; i++)
        begin
            a = addr + addr_t'(i);
            d = fill ? fill_word(a) : data_t'($urandom);
            be = (be_force != '0) ? be_force : byteen_t'($urandom);
            wr_req.write <= 1'b1;
            wr_req.address <= addr;
            wr_req.burstcount <= m_burst_t'(len);
            wr_req.writedata <= d;
            wr_req.byteenable <= be;
            wr_req.user <= user;
            do
            begin
                @(posedge clk);
            end
            while (wr_waitrequest);
            shadow[a[MEM_ADDR_WIDTH-1:0]] = merge_bytes(ref_word(a), d, be);
        end
        wr_req.write <= 1'b0;
        while (wr_rsps < wr_bursts)
        begin
            @(posedge clk);
        end
    endtask

    task automatic read_burst(input addr_t addr, input int len, input user_t user);
        user_t exp_u;
        // Read pieces are never dropped, so their no-reply flag comes back clear
        exp_u = user;
        exp_u[UFLAG_NO_REPLY] = 1'b0;
        for (int i = 0; i < len; i++)
        begin
            rd_exp_q.push_back(ref_word(addr + addr_t'(i)));
            rd_addr_q.push_back(addr + addr_t'(i));
            rd_user_q.push_back(exp_u);
        end
        rd_len_total += len;
        rd_req.read <= 1'b1;
        rd_req.address <= addr;
        rd_req.burstcount <= m_burst_t'(len);
        rd_req.user <= user;
        do
        begin
            @(posedge clk);
        end
        while (rd_waitrequest);
        rd_req.read <= 1'b0;
        while (rd_words < rd_len_total)
        begin
            @(posedge clk);
        end
    endtask

    // Compares every response beat with the expectation queues
    always @(posedge clk)
    begin
        data_t exp_data;
        addr_t exp_addr;
        user_t exp_ruser;
        user_t exp_user;
        if (reset_n && rd_rsp.readdatavalid)
        begin
            assert (rd_exp_q.size() > 0)
            else fail_now($sformatf("FAILED @%0t: read word 0x%08h with no read pending",
                                    $time, rd_rsp.readdata));
            exp_data = rd_exp_q.pop_front();
            exp_addr = rd_addr_q.pop_front();
            exp_ruser = rd_user_q.pop_front();
            assert (rd_rsp.readdata === exp_data)
            else fail_now($sformatf("FAILED @%0t: addr 0x%04h read 0x%08h, expected 0x%08h",
                                    $time, exp_addr, rd_rsp.readdata, exp_data));
            assert (rd_rsp.readresponseuser === exp_ruser)
            else fail_now($sformatf("FAILED @%0t: addr 0x%04h read user 0x%h, expected 0x%h",
                                    $time, exp_addr, rd_rsp.readresponseuser, exp_ruser));
            rd_words <= rd_words + 1;
        end
        if (reset_n && wr_rsp.writeresponsevalid)
        begin
            assert (wr_user_q.size() > 0)
            else fail_now($sformatf("FAILED @%0t: write response with no write pending",
                                    $time));
            exp_user = wr_user_q.pop_front();
            assert (wr_rsp.writeresponseuser === exp_user)
            else fail_now($sformatf("FAILED @%0t: write response user 0x%h, expected 0x%h",
                                    $time, wr_rsp.writeresponseuser, exp_user));
            wr_rsps <= wr_rsps + 1;
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        fail_now($sformatf("watchdog timeout: traffic still pending after %0d ns",
                           TIMEOUT_NS));
    end

    initial
    begin
        int len;
        user_t u;
        void'($urandom(SEED));
        clk = 1'b0;
        reset_n = 1'b0;
        rd_req = '0;
        wr_req = '0;
        rd_len_total = 0;
        wr_bursts = 0;
        rd_words = 0;
        wr_rsps = 0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        // Preload every word so later reads never return unknown data
        for (int b = 0; b < N_FILL; b++)
        begin
            write_burst(addr_t'(b * 16), 16, 4'h2, 1'b1, 4'hf);
        end

        // Single beat round trip
        write_burst(16'h0042, 1, 4'h4, 1'b0, 4'hf);
        read_burst(16'h0042, 1, 4'h6);

        // Unaligned 16-beat bursts that the mapper must cut into pieces
        write_burst(16'h0005, 16, 4'ha, 1'b0, 4'hf);
        read_burst(16'h0005, 16, 4'h0);
        read_burst(16'h1233, 16, 4'he);

        // Partial byte enables keep the other bytes of each word
        write_burst(16'h0021, 1, 4'hc, 1'b0, 4'b0110);
        write_burst(16'h0022, 3, 4'h8, 1'b0, 4'b1001);
        read_burst(16'h0020, 4, 4'h2);

        // Mixed traffic, with the refresh stalls landing on random beats
        for (int n = 0; n < N_RANDOM; n++)
        begin
            len = int'($urandom_range(1, 16));
            u = user_t'($urandom);
            u[UFLAG_NO_REPLY] = 1'b0;
            if ($urandom_range(0, 1) == 1)
            begin
                write_burst(addr_t'($urandom), len, u, 1'b0, '0);
            end
            else
            begin
                read_burst(addr_t'($urandom), len, u);
            end
        end

        // Leave room for any stray response to show up
        repeat (20) @(posedge clk);
        assert (rd_words == rd_len_total)
        else fail_now($sformatf("FAILED @%0t: %0d read words, expected %0d",
                                $time, rd_words, rd_len_total));
        assert (wr_rsps == wr_bursts)
        else fail_now($sformatf("FAILED @%0t: %0d write responses, expected %0d",
                                $time, wr_rsps, wr_bursts));
        $display("TB PASSED");
        $finish;
    end

endmodule
